// ==== src/commu_cfg_pkg.sv ====
// frame path sizing
package commu_cfg_pkg;

	// ------------------------------------------------------------------------
	// storage banks
	// ------------------------------------------------------------------------
	// one frame per bank, rotated on each frame boundary
	localparam int BANK_COUNT  = 4;
	localparam int BANK_SEL_W  = 2;

	// 2048 bytes per bank
	localparam int BANK_ADDR_W = 11;

	// one bit wider than the address so a full bank length fits
	localparam int LEN_W       = 12;

	// ------------------------------------------------------------------------
	// flow control and statistics
	// ------------------------------------------------------------------------
	localparam int CREDIT_W    = 4;
	localparam int CREDIT_MAX  = 8;

	// dropped frame counter, wraps
	localparam int DROP_W      = 8;

endpackage

// ==== src/commu_types_pkg.sv ====
// frame path link types
package commu_types_pkg;

	import commu_cfg_pkg::*;

	// ------------------------------------------------------------------------
	// packer to bank buffer
	// ------------------------------------------------------------------------
	// first byte of the pair sits in data[15:8]
	typedef struct packed {
		logic        vld;
		logic [15:0] data;
		// word closes the frame
		logic        last;
		// low byte is padding
		logic        odd;
		// word opens a frame
		logic        first;
	} pack_word_t;

	// ------------------------------------------------------------------------
	// bank buffer and reader
	// ------------------------------------------------------------------------
	// status of the bank currently selected for reading
	typedef struct packed {
		logic             full;
		logic [LEN_W-1:0] len;
	} bank_status_t;

	// read strobe and bank release
	typedef struct packed {
		logic rd;
		logic release_bank;
	} rd_req_t;

	// ------------------------------------------------------------------------
	// output stream
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic       vld;
		logic [7:0] data;
		logic       last;
	} out_byte_t;

	// reader FSM
	typedef enum logic [1:0] {
		RD_IDLE    = 2'd0,
		RD_STREAM  = 2'd1,
		RD_RELEASE = 2'd2
	} rd_state_t;

endpackage

// ==== src/frame_byte_packer.sv ====
// byte to word packer
module frame_byte_packer
	import commu_types_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       in_vld,
	input  logic [7:0] in_data,
	input  logic       in_last,
	output pack_word_t word
);

	logic        have_byte;
	logic        next_first;
	logic        pair_first;
	logic [7:0]  hold_byte;
	logic        word_vld;
	logic [15:0] word_data;
	logic        word_last;
	logic        word_odd;
	logic        word_first;

	// ------------------------------------------------------------------------
	// pairing control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			have_byte  <= 1'b0;
			next_first <= 1'b1;
			word_vld   <= 1'b0;
		end else begin
			word_vld <= 1'b0;
			if (in_vld) begin
				if (have_byte) begin
					have_byte <= 1'b0;
					word_vld  <= 1'b1;
				end else if (in_last) begin
					// unpaired final byte
					word_vld <= 1'b1;
				end else begin
					have_byte <= 1'b1;
				end
				// byte after a last marker opens the next frame
				next_first <= in_last;
			end
		end
	end

	// word payload
	always_ff @(posedge clk_sys) begin
		if (in_vld) begin
			if (have_byte) begin
				word_data  <= {hold_byte, in_data};
				word_last  <= in_last;
				word_odd   <= 1'b0;
				word_first <= pair_first;
			end else if (in_last) begin
				word_data  <= {in_data, 8'h00};
				word_last  <= 1'b1;
				word_odd   <= 1'b1;
				word_first <= next_first;
			end else begin
				hold_byte  <= in_data;
				pair_first <= next_first;
			end
		end
	end

	assign word = '{vld: word_vld, data: word_data, last: word_last,
	                odd: word_odd, first: word_first};

endmodule

// ==== src/bank_ram.sv ====
// frame storage bank
module bank_ram
	import commu_cfg_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   wr_en,
	input  logic [BANK_ADDR_W-1:0] wr_addr,
	input  logic [7:0]             wr_data,
	input  logic [BANK_ADDR_W-1:0] rd_addr,
	output logic [7:0]             rd_data
);

	logic [7:0] mem [2**BANK_ADDR_W];

	// write port
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== src/frame_bank_buffer.sv ====
// four bank frame buffer
module frame_bank_buffer
	import commu_cfg_pkg::*;
	import commu_types_pkg::*;
(
	input  logic              clk_sys,
	input  logic              rst_n,
	input  pack_word_t        word,
	input  rd_req_t           req,
	output bank_status_t      status,
	output logic [7:0]        q,
	output logic [DROP_W-1:0] drop_count
);

	logic [BANK_SEL_W-1:0]  wr_bank;
	logic [BANK_SEL_W-1:0]  due_bank;
	logic [BANK_SEL_W-1:0]  rd_bank;
	logic [BANK_ADDR_W-1:0] wr_addr;
	logic [BANK_ADDR_W-1:0] rd_addr;
	logic [BANK_COUNT-1:0]  bank_full;
	logic [LEN_W-1:0]       bank_len [BANK_COUNT];
	logic [BANK_COUNT-1:0]  bank_wr_en;
	logic [7:0]             bank_q [BANK_COUNT];
	logic                   dropping;
	logic                   accept;
	logic                   pend_vld;
	logic [7:0]             pend_data;
	logic                   pend_last;
	logic                   wr_en;
	logic [7:0]             wr_data;
	logic                   wr_last;

	// ------------------------------------------------------------------------
	// write side
	// ------------------------------------------------------------------------
	// bank the next frame lands in, one ahead while a final byte is pending
	assign due_bank = (pend_vld && pend_last) ? wr_bank + 1'b1 : wr_bank;

	// first word of a frame decides keep or drop for the whole frame
	assign accept = word.vld && (word.first ? !bank_full[due_bank] : !dropping);

	// high byte now, low byte from the pending slot next cycle.
	// a padded word right behind a pair finds the port busy and waits one cycle
	always_comb begin
		wr_en = pend_vld || accept;
		if (pend_vld) begin
			wr_data = pend_data;
			wr_last = pend_last;
		end else begin
			wr_data = word.data[15:8];
			wr_last = word.last && word.odd;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pend_vld <= 1'b0;
		end else if (pend_vld) begin
			pend_vld <= accept;
		end else begin
			pend_vld <= accept && !word.odd;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			pend_data <= pend_vld ? word.data[15:8] : word.data[7:0];
			pend_last <= word.last;
		end
	end

	// chip select per bank
	for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
		assign bank_wr_en[i] = wr_en && (wr_bank == BANK_SEL_W'(i));

		bank_ram u_bank_ram (
			.clk_sys (clk_sys),
			.wr_en   (bank_wr_en[i]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_addr (rd_addr),
			.rd_data (bank_q[i])
		);
	end

	// ------------------------------------------------------------------------
	// bank bookkeeping
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_bank    <= '0;
			wr_addr    <= '0;
			rd_bank    <= '0;
			rd_addr    <= '0;
			bank_full  <= '0;
			dropping   <= 1'b0;
			drop_count <= '0;
		end else begin
			if (word.vld && word.first) begin
				dropping <= bank_full[due_bank];
				if (bank_full[due_bank]) begin
					drop_count <= drop_count + 1'b1;
				end
			end
			if (wr_en) begin
				if (wr_last) begin
					wr_addr <= '0;
					wr_bank <= wr_bank + 1'b1;
				end else begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
			if (req.release_bank) begin
				rd_addr <= '0;
				rd_bank <= rd_bank + 1'b1;
			end else if (req.rd) begin
				rd_addr <= rd_addr + 1'b1;
			end
			// release and completion never hit the same bank
			if (req.release_bank) begin
				bank_full[rd_bank] <= 1'b0;
			end
			if (wr_en && wr_last) begin
				bank_full[wr_bank] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en && wr_last) begin
			bank_len[wr_bank] <= LEN_W'(wr_addr) + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// read side
	// ------------------------------------------------------------------------
	assign status = '{full: bank_full[rd_bank], len: bank_len[rd_bank]};
	assign q      = bank_q[rd_bank];

endmodule

// ==== src/frame_credit_reader.sv ====
// credit based frame reader
module frame_credit_reader
	import commu_cfg_pkg::*;
	import commu_types_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  bank_status_t status,
	input  logic [7:0]   q,
	input  logic         out_credit,
	output rd_req_t      req,
	output out_byte_t    out
);

	rd_state_t           state;
	logic [CREDIT_W-1:0] credit_cnt;
	logic [LEN_W-1:0]    remain;
	logic                credit_in;
	logic                rd_go;
	logic                out_vld_q;
	logic                out_last_q;

	// ------------------------------------------------------------------------
	// credit counter
	// ------------------------------------------------------------------------
	// grants beyond the outstanding limit are ignored
	assign credit_in = out_credit && (credit_cnt < CREDIT_W'(CREDIT_MAX));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= '0;
		end else begin
			case ({credit_in, rd_go})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// read FSM
	// ------------------------------------------------------------------------
	assign rd_go = (state == RD_STREAM) && (credit_cnt != '0) && (remain != '0);

	assign req = '{rd: rd_go, release_bank: (state == RD_RELEASE)};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state  <= RD_IDLE;
			remain <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (status.full) begin
						remain <= status.len;
						state  <= RD_STREAM;
					end
				end
				RD_STREAM: begin
					if (rd_go) begin
						remain <= remain - 1'b1;
					end else if (remain == '0) begin
						// final byte is on the output this cycle
						state <= RD_RELEASE;
					end
				end
				RD_RELEASE: begin
					state <= RD_IDLE;
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// output byte
	// ------------------------------------------------------------------------
	// flags line up with q from the bank, one cycle after rd
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			out_vld_q  <= 1'b0;
			out_last_q <= 1'b0;
		end else begin
			out_vld_q  <= rd_go;
			out_last_q <= rd_go && (remain == LEN_W'(1));
		end
	end

	assign out = '{vld: out_vld_q, data: q, last: out_last_q};

endmodule

// ==== src/commu_frame_path.sv ====
// frame path top level
module commu_frame_path
	import commu_cfg_pkg::*;
	import commu_types_pkg::*;
(
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              in_vld,
	input  logic [7:0]        in_data,
	input  logic              in_last,
	input  logic              out_credit,
	output out_byte_t         out,
	output logic [DROP_W-1:0] drop_count
);

	pack_word_t   word;
	bank_status_t status;
	rd_req_t      req;
	logic [7:0]   q;

	// decode: bytes to words
	frame_byte_packer u_frame_byte_packer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.in_vld  (in_vld),
		.in_data (in_data),
		.in_last (in_last),
		.word    (word)
	);

	// execute: bank storage
	frame_bank_buffer u_frame_bank_buffer (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.word       (word),
		.req        (req),
		.status     (status),
		.q          (q),
		.drop_count (drop_count)
	);

	// result: credit gated byte stream
	frame_credit_reader u_frame_credit_reader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.status     (status),
		.q          (q),
		.out_credit (out_credit),
		.req        (req),
		.out        (out)
	);

endmodule

// ==== verif/tb_commu_frame_path.sv ====
// frame path testbench
module tb_commu_frame_path
	import commu_cfg_pkg::*;
	import commu_types_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRAIN_LIMIT = 4000;

	logic              clk_sys = 1'b0;
	logic              rst_n;
	logic              in_vld;
	logic [7:0]        in_data;
	logic              in_last;
	logic              out_credit;
	out_byte_t         out_byte;
	logic [DROP_W-1:0] drop_count;

	// {last, data} of every byte still owed by the DUT
	logic [8:0] exp_q [$];
	logic [7:0] frame_buf [256];
	int         seed = 32'ha307;
	int         errors = 0;
	int         checks = 0;
	int         credit_pool;
	int         granted;
	int         received;
	// frames stored and frames seen complete, for bank occupancy
	int         kept;
	int         done;

	always #5 clk_sys = ~clk_sys;

	commu_frame_path u_commu_frame_path (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.in_vld     (in_vld),
		.in_data    (in_data),
		.in_last    (in_last),
		.out_credit (out_credit),
		.out        (out_byte),
		.drop_count (drop_count)
	);

	task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task apply_reset;
		@(posedge clk_sys);
		#1;
		rst_n       = 1'b0;
		credit_pool = 0;
		granted     = 0;
		received    = 0;
		kept        = 0;
		done        = 0;
		exp_q.delete();
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// downstream side
	// ------------------------------------------------------------------------
	// one credit per cycle, never more than CREDIT_MAX outstanding
	task feed_credits;
		forever begin
			@(posedge clk_sys);
			#1;
			if (credit_pool > 0 && (granted - received) < CREDIT_MAX) begin
				out_credit = 1'b1;
				credit_pool--;
				granted++;
			end else begin
				out_credit = 1'b0;
			end
		end
	endtask

	task watch_output;
		logic [8:0] exp;
		forever begin
			@(negedge clk_sys);
			if (rst_n && out_byte.vld) begin
				received++;
				if (received > granted) begin
					errors++;
					$display("byte sent without a credit at %0t", $time);
				end
				if (exp_q.size() == 0) begin
					errors++;
					$display("output byte %0h with no frame expected at %0t", out_byte.data, $time);
				end else begin
					exp = exp_q.pop_front();
					check_value("out data", 32'(out_byte.data), 32'(exp[7:0]));
					check_value("out last", 32'(out_byte.last), 32'(exp[8]));
					if (exp[8]) begin
						done++;
					end
				end
			end else if (out_byte.last) begin
				errors++;
				$display("last flag without a valid byte at %0t", $time);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------------
	task send_frame(input int len);
		int   gap;
		logic keep;
		// a fifth unread frame has no bank and is dropped
		keep = (kept - done) < BANK_COUNT;
		if (keep) begin
			kept++;
		end
		for (int i = 0; i < len; i++) begin
			if (keep) begin
				exp_q.push_back({i == len - 1, frame_buf[i]});
			end
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) begin
				@(posedge clk_sys);
				#1;
				in_vld = 1'b0;
			end
			@(posedge clk_sys);
			#1;
			in_vld  = 1'b1;
			in_data = frame_buf[i];
			in_last = (i == len - 1);
		end
		@(posedge clk_sys);
		#1;
		in_vld  = 1'b0;
		in_last = 1'b0;
	endtask

	task wait_drained;
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout at %0t with %0d bytes never sent", $time, exp_q.size());
		end
	endtask

	task finish_run;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	// ------------------------------------------------------------------------
	// command file
	// ------------------------------------------------------------------------
	initial begin
		int    fd;
		int    code;
		int    arg;
		string cmd;
		logic  parsing;
		rst_n       = 1'b0;
		in_vld      = 1'b0;
		in_data     = 8'h00;
		in_last     = 1'b0;
		out_credit  = 1'b0;
		credit_pool = 0;
		fd = $fopen("verif/commu_frame_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open verif/commu_frame_tests.txt");
		end else begin
			fork
				feed_credits();
				watch_output();
			join_none
			apply_reset();
			parsing = 1'b1;
			while (parsing) begin
				code = $fscanf(fd, " %s", cmd);
				if (code != 1) begin
					parsing = 1'b0;
				end else if (cmd.getc(0) == "#") begin
					code = $fgets(cmd, fd);
				end else if (cmd == "R") begin
					apply_reset();
				end else if (cmd == "W") begin
					wait_drained();
				end else if (cmd == "C" || cmd == "D" || cmd == "F") begin
					code = $fscanf(fd, "%d", arg);
					if (cmd == "C") begin
						credit_pool += arg;
					end else if (cmd == "D") begin
						check_value("drop_count", 32'(drop_count), 32'(arg));
					end else if (arg < 1 || arg > 256) begin
						errors++;
						parsing = 1'b0;
						$display("frame length %0d out of range in test file", arg);
					end else begin
						for (int i = 0; i < arg; i++) begin
							code = $fscanf(fd, "%h", frame_buf[i]);
						end
						send_frame(arg);
					end
				end else begin
					errors++;
					parsing = 1'b0;
					$display("unknown command %s in test file", cmd);
				end
			end
			$fclose(fd);
			// quiet tail catches stray output
			repeat (50) @(posedge clk_sys);
			if (exp_q.size() != 0) begin
				errors++;
				$display("%0d expected bytes still missing at end of run", exp_q.size());
			end
		end
		finish_run();
	end

endmodule

// ==== filelist.f ====
src/commu_cfg_pkg.sv
src/commu_types_pkg.sv
src/frame_byte_packer.sv
src/bank_ram.sv
src/frame_bank_buffer.sv
src/frame_credit_reader.sv
src/commu_frame_path.sv
verif/tb_commu_frame_path.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing
TOP       := tb_commu_frame_path
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/commu_frame_tests.txt ====
# R reset | C n credits | F len then len hex bytes | D n drop count | W wait for output
# C, D and F lengths are decimal
R
# even, odd and single byte frames
C 17
F 1 a5
F 2 01 02
F 3 10 20 30
F 4 de ad be ef
F 7 00 11 22 33 44 55 66
W
D 0
# no credits, then partial, then the rest
F 5 c1 c2 c3 c4 c5
F 3 d1 d2 d3
C 4
F 2 e1 e2
C 6
W
# six frames across the bank wrap
C 30
F 3 01 12 23
F 4 34 45 56 67
F 5 78 89 9a ab bc
F 6 cd de ef f0 0f 1e
F 5 2d 3c 4b 5a 69
F 7 87 96 a5 b4 c3 d2 e1
W
D 0
# banks fill with no credits, fifth frame dropped
R
F 10 40 41 42 43 44 45 46 47 48 49
F 10 50 51 52 53 54 55 56 57 58 59
F 10 60 61 62 63 64 65 66 67 68 69
F 10 70 71 72 73 74 75 76 77 78 79
F 10 80 81 82 83 84 85 86 87 88 89
D 1
C 40
W
D 1
# reset while a frame streams out
F 12 90 91 92 93 94 95 96 97 98 99 9a 9b
F 9 a0 a1 a2 a3 a4 a5 a6 a7 a8
C 5
F 3 b0 b1 b2
R
D 0
F 6 f1 f2 f3 f4 f5 f6
C 6
W
D 0
